// ==== btac_defines.svh ====
`ifndef BTAC_DEFINES_SVH
`define BTAC_DEFINES_SVH

// instruction address width.
`define BTAC_ADDR_W 32

// entries in the direct-mapped buffer.
`define BTAC_DEPTH 64

// log2 of the depth, so the index is pc[7:2].
`define BTAC_INDEX_W 6

`endif

// ==== btac_pkg.sv ====
`default_nettype none

`include "btac_defines.svh"

package btac_pkg;

  typedef logic [`BTAC_ADDR_W-1:0] addr_t;
  typedef logic [`BTAC_INDEX_W-1:0] btb_index_t;

  // all-zero entry means empty.
  typedef struct packed {
    addr_t target;
    addr_t pc;
    addr_t npc;
  } btb_entry_t;

  typedef struct packed {
    logic clear;
    addr_t fetch_pc0;
    addr_t fetch_pc1;
    addr_t upd_pc0;
    addr_t upd_npc0;
    addr_t upd_addr0;
    logic upd_jal0;
    logic upd_branch0;
    logic upd_jump0;
    addr_t upd_pc1;
    addr_t upd_npc1;
    addr_t upd_addr1;
    logic upd_jal1;
    logic upd_branch1;
    logic upd_jump1;
    // prediction the fetch stage acted on.
    logic taken;
    addr_t taddr;
    addr_t tpc;
    addr_t tnpc;
  } btac_in_t;

  typedef struct packed {
    logic pred_branch;
    addr_t pred_baddr;
    addr_t pred_pc;
    addr_t pred_npc;
    logic pred_miss;
    addr_t pred_maddr;
  } btac_out_t;

  typedef struct packed {
    btb_index_t raddr0;
    btb_index_t raddr1;
  } btb_read_t;

  typedef struct packed {
    logic wen;
    btb_index_t waddr;
    btb_entry_t wdata;
  } btb_write_t;

  typedef struct packed {
    btb_entry_t rdata0;
    btb_entry_t rdata1;
  } btb_out_t;

endpackage

`default_nettype wire

// ==== btac_btb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "btac_defines.svh"

module btac_btb (
  input  logic                 clock,
  input  btac_pkg::btb_read_t  btb_read,
  input  btac_pkg::btb_write_t btb_write,
  output btac_pkg::btb_out_t   btb_out
);

  btac_pkg::btb_entry_t btb_array [0:`BTAC_DEPTH-1] = '{default: '0};

  // read indices held for the cycle after the fetch.
  btac_pkg::btb_index_t raddr0 = '0;
  btac_pkg::btb_index_t raddr1 = '0;

  always_ff @(posedge clock) begin
    raddr0 <= btb_read.raddr0;
    raddr1 <= btb_read.raddr1;
    if (btb_write.wen) begin
      btb_array[btb_write.waddr] <= btb_write.wdata;
    end
  end

  // asynchronous read, so a write lands before the next lookup.
  assign btb_out.rdata0 = btb_array[raddr0];
  assign btb_out.rdata1 = btb_array[raddr1];

endmodule

`default_nettype wire

// ==== btac_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "btac_defines.svh"

module btac_lookup (
  input  logic                 clock,
  input  logic                 reset,
  input  btac_pkg::btac_in_t   btac_in,
  input  btac_pkg::btb_out_t   btb_out,
  output btac_pkg::btb_read_t  btb_read,
  output btac_pkg::btac_out_t  prediction
);

  btac_pkg::addr_t pc0_q;
  btac_pkg::addr_t pc1_q;
  btac_pkg::btb_index_t raddr0_q;
  btac_pkg::btb_index_t raddr1_q;

  btac_pkg::addr_t pc0_d;
  btac_pkg::addr_t pc1_d;
  btac_pkg::btb_index_t raddr0_d;
  btac_pkg::btb_index_t raddr1_d;

  logic hit0;
  logic hit1;

  // hold the last fetch while flushing.
  always_comb begin
    pc0_d = pc0_q;
    pc1_d = pc1_q;
    raddr0_d = raddr0_q;
    raddr1_d = raddr1_q;
    if (!btac_in.clear) begin
      pc0_d = btac_in.fetch_pc0;
      pc1_d = btac_in.fetch_pc1;
      raddr0_d = btac_in.fetch_pc0[`BTAC_INDEX_W+1:2];
      raddr1_d = btac_in.fetch_pc1[`BTAC_INDEX_W+1:2];
    end
  end

  assign btb_read.raddr0 = raddr0_d;
  assign btb_read.raddr1 = raddr1_d;

  always_ff @(posedge clock) begin
    if (!reset) begin
      pc0_q <= '0;
      pc1_q <= '0;
      raddr0_q <= '0;
      raddr1_q <= '0;
    end else begin
      pc0_q <= pc0_d;
      pc1_q <= pc1_d;
      raddr0_q <= raddr0_d;
      raddr1_q <= raddr1_d;
    end
  end

  // tag check against the full pc.
  assign hit0 = (|btb_out.rdata0) && (btb_out.rdata0.pc == pc0_q);
  assign hit1 = (|btb_out.rdata1) && (btb_out.rdata1.pc == pc1_q);

  // lane 0 has priority.
  always_comb begin
    prediction = '0;
    if (!btac_in.clear) begin
      prediction.pred_branch = hit0 | hit1;
      prediction.pred_baddr = hit0 ? btb_out.rdata0.target : btb_out.rdata1.target;
      prediction.pred_pc = hit0 ? btb_out.rdata0.pc : btb_out.rdata1.pc;
      prediction.pred_npc = hit0 ? btb_out.rdata0.npc : btb_out.rdata1.npc;
    end
  end

endmodule

`default_nettype wire

// ==== btac_resolve.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "btac_defines.svh"

module btac_resolve (
  input  logic                 clock,
  input  logic                 reset,
  input  btac_pkg::btac_in_t   btac_in,
  output btac_pkg::btb_write_t btb_write,
  output btac_pkg::btac_out_t  verdict
);

  // taken record.
  logic taken_q;
  btac_pkg::addr_t taddr_q;
  btac_pkg::addr_t tpc_q;
  btac_pkg::addr_t tnpc_q;

  // record in effect this cycle.
  logic live;
  btac_pkg::addr_t rec_taddr;
  btac_pkg::addr_t rec_tpc;
  btac_pkg::addr_t rec_tnpc;

  logic consume;
  logic miss;
  btac_pkg::addr_t maddr;

  // one lane resolving the acted-on prediction; returns 1 if consumed.
  function automatic logic resolve_lane(
    input  logic            jump,
    input  logic            branch,
    input  btac_pkg::addr_t addr,
    input  btac_pkg::addr_t taddr,
    input  btac_pkg::addr_t tnpc,
    output logic            lane_miss,
    output btac_pkg::addr_t lane_maddr
  );
    lane_miss = 1'b0;
    lane_maddr = '0;
    if (jump) begin
      lane_maddr = addr;
      lane_miss = (addr != taddr);
    end else if (branch) begin
      // predicted taken but fell through.
      lane_maddr = tnpc;
      lane_miss = 1'b1;
    end
    return jump | branch;
  endfunction

  always_comb begin
    btb_write = '0;
    if (!btac_in.clear) begin
      btb_write.wen = ((btac_in.upd_jal0 | btac_in.upd_branch0) & btac_in.upd_jump0) |
                      ((btac_in.upd_jal1 | btac_in.upd_branch1) & btac_in.upd_jump1);
      if (btac_in.upd_jump0) begin
        btb_write.waddr = btac_in.upd_pc0[`BTAC_INDEX_W+1:2];
        btb_write.wdata = '{target: btac_in.upd_addr0, pc: btac_in.upd_pc0,
                            npc: btac_in.upd_npc0};
      end else begin
        btb_write.waddr = btac_in.upd_pc1[`BTAC_INDEX_W+1:2];
        btb_write.wdata = '{target: btac_in.upd_addr1, pc: btac_in.upd_pc1,
                            npc: btac_in.upd_npc1};
      end
    end
  end

  // a new record is usable in the cycle it arrives.
  always_comb begin
    live = taken_q;
    rec_taddr = taddr_q;
    rec_tpc = tpc_q;
    rec_tnpc = tnpc_q;
    if (btac_in.clear) begin
      live = 1'b0;
      rec_taddr = '0;
      rec_tpc = '0;
      rec_tnpc = '0;
    end else if (btac_in.taken) begin
      live = 1'b1;
      rec_taddr = btac_in.taddr;
      rec_tpc = btac_in.tpc;
      rec_tnpc = btac_in.tnpc;
    end
  end

  always_comb begin
    miss = 1'b0;
    maddr = '0;
    consume = 1'b0;
    if (!btac_in.clear) begin
      if (live && btac_in.upd_pc0 == rec_tpc) begin
        consume = resolve_lane(btac_in.upd_jump0, btac_in.upd_branch0, btac_in.upd_addr0,
                               rec_taddr, rec_tnpc, miss, maddr);
      end else if (live && btac_in.upd_pc1 == rec_tpc) begin
        consume = resolve_lane(btac_in.upd_jump1, btac_in.upd_branch1, btac_in.upd_addr1,
                               rec_taddr, rec_tnpc, miss, maddr);
      end else if (btac_in.upd_jump0) begin
        // unpredicted redirect.
        miss = 1'b1;
        maddr = btac_in.upd_addr0;
        consume = 1'b1;
      end else if (btac_in.upd_jump1) begin
        miss = 1'b1;
        maddr = btac_in.upd_addr1;
        consume = 1'b1;
      end
    end
  end

  always_comb begin
    verdict = '0;
    verdict.pred_miss = miss;
    verdict.pred_maddr = maddr;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      taken_q <= 1'b0;
      taddr_q <= '0;
      tpc_q <= '0;
      tnpc_q <= '0;
    end else begin
      taken_q <= live & ~consume;
      taddr_q <= rec_taddr;
      tpc_q <= rec_tpc;
      tnpc_q <= rec_tnpc;
    end
  end

endmodule

`default_nettype wire

// ==== btac.sv ====
`timescale 1ns/1ps
`default_nettype none

module btac (
  input  logic                clock,
  input  logic                reset,
  input  btac_pkg::btac_in_t  btac_in,
  output btac_pkg::btac_out_t btac_out
);

  btac_pkg::btb_read_t btb_read;
  btac_pkg::btb_write_t btb_write;
  btac_pkg::btb_out_t btb_out;
  btac_pkg::btac_out_t prediction;
  btac_pkg::btac_out_t verdict;

  btac_lookup lookup_inst (
    .clock      (clock),
    .reset      (reset),
    .btac_in    (btac_in),
    .btb_out    (btb_out),
    .btb_read   (btb_read),
    .prediction (prediction)
  );

  btac_resolve resolve_inst (
    .clock     (clock),
    .reset     (reset),
    .btac_in   (btac_in),
    .btb_write (btb_write),
    .verdict   (verdict)
  );

  btac_btb btb_inst (
    .clock     (clock),
    .btb_read  (btb_read),
    .btb_write (btb_write),
    .btb_out   (btb_out)
  );

  // branch fields from lookup, miss fields from resolve.
  assign btac_out.pred_branch = prediction.pred_branch;
  assign btac_out.pred_baddr = prediction.pred_baddr;
  assign btac_out.pred_pc = prediction.pred_pc;
  assign btac_out.pred_npc = prediction.pred_npc;
  assign btac_out.pred_miss = verdict.pred_miss;
  assign btac_out.pred_maddr = verdict.pred_maddr;

endmodule

`default_nettype wire

// ==== btac_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module btac_sva (
  input logic                clock,
  input logic                reset,
  input btac_pkg::btac_in_t  btac_in,
  input btac_pkg::btac_out_t btac_out,
  input btac_pkg::btb_write_t btb_write
);

  logic quiet;

  assign quiet = !btac_in.clear && !btac_in.taken &&
                 !(btac_in.upd_jal0 | btac_in.upd_branch0 | btac_in.upd_jump0) &&
                 !(btac_in.upd_jal1 | btac_in.upd_branch1 | btac_in.upd_jump1);

  // flush silences the outputs.
  clear_outputs: assert property (@(posedge clock) disable iff (!reset)
    btac_in.clear |-> btac_out == '0)
    else $error("outputs not zero during clear");

  clear_write: assert property (@(posedge clock) disable iff (!reset)
    btac_in.clear |-> !btb_write.wen)
    else $error("buffer written during clear");

  // first cycle out of reset.
  reset_release: assert property (@(posedge clock)
    ($rose(reset) && quiet) |-> (!btac_out.pred_branch && !btac_out.pred_miss))
    else $error("prediction or miss in the first cycle after reset");

endmodule

bind btac btac_sva sva_inst (
  .clock     (clock),
  .reset     (reset),
  .btac_in   (btac_in),
  .btac_out  (btac_out),
  .btb_write (btb_write)
);

`default_nettype wire

// ==== tb_btac.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "btac_defines.svh"

module tb_btac;

  logic clock;
  logic reset;
  btac_pkg::btac_in_t btac_in;
  btac_pkg::btac_out_t btac_out;

  // reference model state.
  btac_pkg::btb_entry_t model_btb [0:`BTAC_DEPTH-1];
  btac_pkg::addr_t model_pc0;
  btac_pkg::addr_t model_pc1;
  logic rec_live;
  btac_pkg::addr_t rec_taddr;
  btac_pkg::addr_t rec_tpc;
  btac_pkg::addr_t rec_tnpc;

  // model next state committed at the rising edge.
  logic nxt_live;
  btac_pkg::addr_t nxt_taddr;
  btac_pkg::addr_t nxt_tpc;
  btac_pkg::addr_t nxt_tnpc;
  logic wr_en;
  btac_pkg::btb_index_t wr_idx;
  btac_pkg::btb_entry_t wr_entry;

  logic [31:0] lcg_state;

  btac DUT (
    .clock    (clock),
    .reset    (reset),
    .btac_in  (btac_in),
    .btac_out (btac_out)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  // 16 word-aligned pcs; sel and sel+8 share an index.
  function automatic btac_pkg::addr_t pool_pc(input logic [3:0] sel);
    return 32'h2000 + (32'(sel[3]) << 9) + (32'(sel[2:0]) << 2);
  endfunction

  function automatic btac_pkg::addr_t pick_pc();
    return pool_pc(4'(lcg_next()));
  endfunction

  task automatic wait_edge(input logic level);
    int changes;
    changes = 0;
    while (changes < 4) begin
      @(clock);
      changes++;
      if (clock === level) return;
    end
    $display("clock stalled, no edge to level %b seen", level);
    $display("TESTS FAILED");
    $fatal(1, "clock stalled");
  endtask

  task automatic check_prediction(input btac_pkg::btac_out_t got,
                                  input btac_pkg::btac_out_t exp);
    if (got.pred_branch !== exp.pred_branch || got.pred_baddr !== exp.pred_baddr ||
        got.pred_pc !== exp.pred_pc || got.pred_npc !== exp.pred_npc) begin
      $display("ERROR at %0t: prediction got %b %h %h %h, expected %b %h %h %h", $time,
               got.pred_branch, got.pred_baddr, got.pred_pc, got.pred_npc,
               exp.pred_branch, exp.pred_baddr, exp.pred_pc, exp.pred_npc);
      $display("TESTS FAILED");
      $fatal(1, "prediction mismatch");
    end
  endtask

  task automatic check_verdict(input btac_pkg::btac_out_t got, input btac_pkg::btac_out_t exp);
    if (got.pred_miss !== exp.pred_miss || got.pred_maddr !== exp.pred_maddr) begin
      $display("ERROR at %0t: verdict got %b %h, expected %b %h", $time,
               got.pred_miss, got.pred_maddr, exp.pred_miss, exp.pred_maddr);
      $display("TESTS FAILED");
      $fatal(1, "verdict mismatch");
    end
  endtask

  task automatic compute_expected(output btac_pkg::btac_out_t exp);
    btac_pkg::btb_entry_t e0;
    btac_pkg::btb_entry_t e1;
    logic hit0;
    logic hit1;
    logic live;
    logic used;
    logic jump;
    logic branch;
    btac_pkg::addr_t addr;
    btac_pkg::addr_t tpc;
    exp = '0;
    wr_en = 1'b0;
    nxt_live = 1'b0;
    nxt_taddr = '0;
    nxt_tpc = '0;
    nxt_tnpc = '0;
    if (btac_in.clear) return;
    e0 = model_btb[model_pc0[7:2]];
    e1 = model_btb[model_pc1[7:2]];
    hit0 = (e0 != '0) && (e0.pc == model_pc0);
    hit1 = (e1 != '0) && (e1.pc == model_pc1);
    exp.pred_branch = hit0 | hit1;
    exp.pred_baddr = hit0 ? e0.target : e1.target;
    exp.pred_pc = hit0 ? e0.pc : e1.pc;
    exp.pred_npc = hit0 ? e0.npc : e1.npc;
    wr_en = ((btac_in.upd_jal0 | btac_in.upd_branch0) & btac_in.upd_jump0) |
            ((btac_in.upd_jal1 | btac_in.upd_branch1) & btac_in.upd_jump1);
    if (btac_in.upd_jump0) begin
      wr_idx = btac_in.upd_pc0[7:2];
      wr_entry = '{target: btac_in.upd_addr0, pc: btac_in.upd_pc0, npc: btac_in.upd_npc0};
    end else begin
      wr_idx = btac_in.upd_pc1[7:2];
      wr_entry = '{target: btac_in.upd_addr1, pc: btac_in.upd_pc1, npc: btac_in.upd_npc1};
    end
    live = rec_live | btac_in.taken;
    nxt_taddr = btac_in.taken ? btac_in.taddr : rec_taddr;
    nxt_tpc = btac_in.taken ? btac_in.tpc : rec_tpc;
    nxt_tnpc = btac_in.taken ? btac_in.tnpc : rec_tnpc;
    tpc = nxt_tpc;
    used = 1'b0;
    if (live && (btac_in.upd_pc0 == tpc || btac_in.upd_pc1 == tpc)) begin
      jump = (btac_in.upd_pc0 == tpc) ? btac_in.upd_jump0 : btac_in.upd_jump1;
      branch = (btac_in.upd_pc0 == tpc) ? btac_in.upd_branch0 : btac_in.upd_branch1;
      addr = (btac_in.upd_pc0 == tpc) ? btac_in.upd_addr0 : btac_in.upd_addr1;
      if (jump) begin
        exp.pred_miss = (addr != nxt_taddr);
        exp.pred_maddr = addr;
        used = 1'b1;
      end else if (branch) begin
        exp.pred_miss = 1'b1;
        exp.pred_maddr = nxt_tnpc;
        used = 1'b1;
      end
    end else if (btac_in.upd_jump0 | btac_in.upd_jump1) begin
      exp.pred_miss = 1'b1;
      exp.pred_maddr = btac_in.upd_jump0 ? btac_in.upd_addr0 : btac_in.upd_addr1;
      used = 1'b1;
    end
    nxt_live = live & ~used;
  endtask

  task automatic update_model();
    if (wr_en) model_btb[wr_idx] = wr_entry;
    if (!btac_in.clear) begin
      model_pc0 = btac_in.fetch_pc0;
      model_pc1 = btac_in.fetch_pc1;
    end
    rec_live = nxt_live;
    rec_taddr = nxt_taddr;
    rec_tpc = nxt_tpc;
    rec_tnpc = nxt_tnpc;
  endtask

  // one cycle from falling edge to falling edge.
  task automatic step(input btac_pkg::btac_in_t stim);
    btac_pkg::btac_out_t exp;
    btac_in = stim;
    #10;
    compute_expected(exp);
    check_prediction(btac_out, exp);
    check_verdict(btac_out, exp);
    wait_edge(1'b1);
    update_model();
    wait_edge(1'b0);
  endtask

  function automatic btac_pkg::btac_in_t fetch_only(input btac_pkg::addr_t f0,
                                                    input btac_pkg::addr_t f1);
    btac_pkg::btac_in_t r;
    r = '0;
    r.fetch_pc0 = f0;
    r.fetch_pc1 = f1;
    return r;
  endfunction

  function automatic btac_pkg::btac_in_t with_update(input btac_pkg::btac_in_t s,
      input logic lane, input btac_pkg::addr_t pc, input btac_pkg::addr_t addr,
      input logic branch, input logic jump);
    btac_pkg::btac_in_t r;
    r = s;
    if (!lane) begin
      r.upd_pc0 = pc;
      r.upd_npc0 = pc + 4;
      r.upd_addr0 = addr;
      r.upd_jal0 = jump & ~branch;
      r.upd_branch0 = branch;
      r.upd_jump0 = jump;
    end else begin
      r.upd_pc1 = pc;
      r.upd_npc1 = pc + 4;
      r.upd_addr1 = addr;
      r.upd_jal1 = jump & ~branch;
      r.upd_branch1 = branch;
      r.upd_jump1 = jump;
    end
    return r;
  endfunction

  function automatic btac_pkg::btac_in_t with_taken(input btac_pkg::btac_in_t s,
      input btac_pkg::addr_t tpc, input btac_pkg::addr_t taddr);
    btac_pkg::btac_in_t r;
    r = s;
    r.taken = 1'b1;
    r.tpc = tpc;
    r.taddr = taddr;
    r.tnpc = tpc + 4;
    return r;
  endfunction

  // resolutions often aim at the live record so that matches occur.
  function automatic btac_pkg::btac_in_t random_stim();
    btac_pkg::btac_in_t s;
    s = fetch_only(pick_pc(), pick_pc());
    s.clear = (lcg_next() % 16) == 0;
    s.upd_pc0 = (rec_live && lcg_next() % 3 == 0) ? rec_tpc : pick_pc();
    s.upd_npc0 = s.upd_pc0 + 4;
    s.upd_addr0 = (lcg_next() % 2 == 0) ? rec_taddr : pick_pc();
    {s.upd_jal0, s.upd_branch0, s.upd_jump0} = 3'(lcg_next());
    s.upd_pc1 = (rec_live && lcg_next() % 3 == 0) ? rec_tpc : pick_pc();
    s.upd_npc1 = s.upd_pc1 + 4;
    s.upd_addr1 = (lcg_next() % 2 == 0) ? rec_taddr : pick_pc();
    {s.upd_jal1, s.upd_branch1, s.upd_jump1} = 3'(lcg_next());
    s.taken = (lcg_next() % 4) == 0;
    s.tpc = pick_pc();
    s.tnpc = s.tpc + 4;
    s.taddr = pick_pc();
    return s;
  endfunction

  initial begin
    btac_pkg::btac_in_t s;
    int i;
    lcg_state = 32'd13;
    reset = 1'b0;
    btac_in = '0;
    for (i = 0; i < `BTAC_DEPTH; i++) model_btb[i] = '0;
    model_pc0 = '0;
    model_pc1 = '0;
    rec_live = 1'b0;
    rec_taddr = '0;
    rec_tpc = '0;
    rec_tnpc = '0;
    for (i = 0; i < 10; i++) wait_edge(1'b1);
    wait_edge(1'b0);
    reset = 1'b1;
    step('0);
    // two jumps written, then hit, alias, empty and dual-hit lookups.
    step(with_update(fetch_only(pool_pc(1), pool_pc(2)), 1'b0, pool_pc(1), pool_pc(5),
                     1'b0, 1'b1));
    step(with_update(fetch_only(pool_pc(1), pool_pc(2)), 1'b1, pool_pc(2), pool_pc(6),
                     1'b0, 1'b1));
    step(fetch_only(pool_pc(9), pool_pc(3)));
    step(fetch_only(pool_pc(2), pool_pc(1)));
    step('0);
    // taken record resolved in four ways.
    s = with_taken('0, pool_pc(1), pool_pc(5));
    step(with_update(s, 1'b0, pool_pc(1), pool_pc(5), 1'b0, 1'b1));
    step(with_taken('0, pool_pc(2), pool_pc(6)));
    step(with_update('0, 1'b1, pool_pc(2), pool_pc(7), 1'b0, 1'b1));
    step(with_update(with_taken('0, pool_pc(3), pool_pc(4)), 1'b0, pool_pc(3), '0,
                     1'b1, 1'b0));
    step(with_update(with_taken('0, pool_pc(5), pool_pc(6)), 1'b1, pool_pc(10),
                     pool_pc(11), 1'b0, 1'b1));
    // flush with a live record and a pending jump.
    step(with_taken('0, pool_pc(4), pool_pc(8)));
    s = with_update(fetch_only(pool_pc(12), pool_pc(12)), 1'b0, pool_pc(12), pool_pc(13),
                    1'b0, 1'b1);
    s.clear = 1'b1;
    step(s);
    step(fetch_only(pool_pc(12), pool_pc(12)));
    step(with_update('0, 1'b0, pool_pc(4), pool_pc(8), 1'b1, 1'b0));
    for (i = 0; i < 3000; i++) step(random_stim());
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
btac_pkg.sv
btac_btb.sv
btac_lookup.sv
btac_resolve.sv
btac.sv
btac_sva.sv
tb_btac.sv

// ==== Makefile ====
TOP = tb_btac

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | awk '{ print } /^TESTS PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
